// ==== src/cpuCtrlPkg.sv ====
`default_nettype none

package cpuCtrlPkg;

	localparam int OPCODE_W = 6;
	localparam int ALUOP_W = 5;
	localparam int ALUSRC_W = 2;
	localparam int MEMTOREG_W = 2;
	localparam int MEMOUT_W = 2;

	// opcodes of the kept instruction groups
	localparam logic [OPCODE_W-1:0] OP_NOP = 6'b000000;
	localparam logic [OPCODE_W-1:0] OP_HALT = 6'b000001;
	localparam logic [OPCODE_W-1:0] OP_ADD = 6'b000010;
	localparam logic [OPCODE_W-1:0] OP_ADDI = 6'b000011;
	localparam logic [OPCODE_W-1:0] OP_SUB = 6'b000100;
	localparam logic [OPCODE_W-1:0] OP_SUBI = 6'b000101;
	localparam logic [OPCODE_W-1:0] OP_MULT = 6'b000110;
	localparam logic [OPCODE_W-1:0] OP_DIV = 6'b000111;
	localparam logic [OPCODE_W-1:0] OP_SLT = 6'b001000;
	localparam logic [OPCODE_W-1:0] OP_SHR = 6'b001001;
	localparam logic [OPCODE_W-1:0] OP_SHL = 6'b001010;
	localparam logic [OPCODE_W-1:0] OP_LW = 6'b001011;
	localparam logic [OPCODE_W-1:0] OP_LI = 6'b001100;
	localparam logic [OPCODE_W-1:0] OP_SW = 6'b001101;
	localparam logic [OPCODE_W-1:0] OP_JUMP = 6'b001110;
	localparam logic [OPCODE_W-1:0] OP_JR = 6'b001111;
	localparam logic [OPCODE_W-1:0] OP_XOR = 6'b010000;
	localparam logic [OPCODE_W-1:0] OP_AND = 6'b010001;
	localparam logic [OPCODE_W-1:0] OP_OR = 6'b010010;
	localparam logic [OPCODE_W-1:0] OP_NOT = 6'b010011;
	localparam logic [OPCODE_W-1:0] OP_XORI = 6'b010100;
	localparam logic [OPCODE_W-1:0] OP_ANDI = 6'b010101;
	localparam logic [OPCODE_W-1:0] OP_ORI = 6'b010110;
	localparam logic [OPCODE_W-1:0] OP_BEQ = 6'b010111;
	localparam logic [OPCODE_W-1:0] OP_BNEQ = 6'b011000;
	localparam logic [OPCODE_W-1:0] OP_BEQZ = 6'b011001;
	localparam logic [OPCODE_W-1:0] OP_BNEQZ = 6'b011010;
	localparam logic [OPCODE_W-1:0] OP_BGT = 6'b011011;
	localparam logic [OPCODE_W-1:0] OP_BLT = 6'b011100;
	localparam logic [OPCODE_W-1:0] OP_BGTZ = 6'b011101;
	localparam logic [OPCODE_W-1:0] OP_BLTZ = 6'b011110;
	localparam logic [OPCODE_W-1:0] OP_IN = 6'b011111;
	localparam logic [OPCODE_W-1:0] OP_OUT = 6'b100000;
	localparam logic [OPCODE_W-1:0] OP_JAL = 6'b100001;
	localparam logic [OPCODE_W-1:0] OP_SEND = 6'b110011; // gap holds the retired OS ops
	localparam logic [OPCODE_W-1:0] OP_RECV = 6'b110100;

	// ALU operations
	localparam logic [ALUOP_W-1:0] ALU_ADD = 5'b00000;
	localparam logic [ALUOP_W-1:0] ALU_SUB = 5'b00001;
	localparam logic [ALUOP_W-1:0] ALU_MUL = 5'b00010;
	localparam logic [ALUOP_W-1:0] ALU_DIV = 5'b00011;
	localparam logic [ALUOP_W-1:0] ALU_NOT = 5'b00100;
	localparam logic [ALUOP_W-1:0] ALU_AND = 5'b00101;
	localparam logic [ALUOP_W-1:0] ALU_OR = 5'b00110;
	localparam logic [ALUOP_W-1:0] ALU_XOR = 5'b00111;
	localparam logic [ALUOP_W-1:0] ALU_SHL = 5'b01000;
	localparam logic [ALUOP_W-1:0] ALU_SHR = 5'b01001;
	localparam logic [ALUOP_W-1:0] ALU_SLT = 5'b01010;
	localparam logic [ALUOP_W-1:0] ALU_SGT = 5'b01011;
	localparam logic [ALUOP_W-1:0] ALU_EQ = 5'b01100;
	localparam logic [ALUOP_W-1:0] ALU_NEQ = 5'b01111; // not contiguous with EQ

	localparam logic [ALUSRC_W-1:0] ASRC_REG = 2'b00; // second operand from rt
	localparam logic [ALUSRC_W-1:0] ASRC_IMM = 2'b01;

	localparam logic [MEMTOREG_W-1:0] MTG_ALU = 2'b00;
	localparam logic [MEMTOREG_W-1:0] MTG_MEM = 2'b01;

	localparam logic [MEMOUT_W-1:0] MO_NONE = 2'b00;
	localparam logic [MEMOUT_W-1:0] MO_PORT = 2'b01; // input port value
	localparam logic [MEMOUT_W-1:0] MO_UART = 2'b10; // received serial byte

endpackage

`default_nettype wire

// ==== src/datapathDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapathDecoder (
	input logic [cpuCtrlPkg::OPCODE_W-1:0] opcode,
	output logic regWrite,
	output logic regDst,
	output logic [cpuCtrlPkg::ALUSRC_W-1:0] aluSrc,
	output logic [cpuCtrlPkg::MEMTOREG_W-1:0] memToReg,
	output logic memWrite,
	output logic [cpuCtrlPkg::ALUOP_W-1:0] aluOp
);
	import cpuCtrlPkg::*;

	// register file, operand and memory controls
	always_comb
	begin
		regWrite = 1'b0;
		regDst = 1'b0;
		aluSrc = ASRC_REG;
		memToReg = MTG_ALU;
		memWrite = 1'b0;
		case (opcode)
			OP_ADD, OP_SUB, OP_MULT, OP_DIV, OP_SLT, OP_XOR, OP_AND, OP_OR:
			begin
				regWrite = 1'b1;
				regDst = 1'b1; // write to rd
			end
			OP_SHR, OP_SHL, OP_NOT, OP_JAL:
			begin
				regWrite = 1'b1;
			end
			OP_ADDI, OP_SUBI, OP_XORI, OP_ANDI, OP_ORI, OP_LI, OP_IN, OP_RECV:
			begin
				regWrite = 1'b1;
				aluSrc = ASRC_IMM;
			end
			OP_LW:
			begin
				regWrite = 1'b1;
				aluSrc = ASRC_IMM; // base plus offset
				memToReg = MTG_MEM;
			end
			OP_SW:
			begin
				memWrite = 1'b1;
				aluSrc = ASRC_IMM;
			end
			OP_OUT, OP_SEND:
			begin
				aluSrc = ASRC_IMM;
				memToReg = MTG_MEM; // data word read from memory
			end
			OP_JUMP:
			begin
				aluSrc = ASRC_IMM;
			end
			default:
			begin
				// nop, halt, jr, branches and unknown ops keep the idle values
			end
		endcase
	end

	// ALU operation with the branch comparisons
	always_comb
	begin
		case (opcode)
			OP_SUB, OP_SUBI:
				aluOp = ALU_SUB;
			OP_MULT:
				aluOp = ALU_MUL;
			OP_DIV:
				aluOp = ALU_DIV;
			OP_NOT:
				aluOp = ALU_NOT;
			OP_AND, OP_ANDI:
				aluOp = ALU_AND;
			OP_OR, OP_ORI:
				aluOp = ALU_OR;
			OP_XOR, OP_XORI:
				aluOp = ALU_XOR;
			OP_SHL:
				aluOp = ALU_SHL;
			OP_SHR:
				aluOp = ALU_SHR;
			OP_SLT, OP_BLT, OP_BLTZ:
				aluOp = ALU_SLT;
			OP_BGT, OP_BGTZ:
				aluOp = ALU_SGT;
			OP_BEQ, OP_BEQZ:
				aluOp = ALU_EQ; // zero forms compare against r0
			OP_BNEQ, OP_BNEQZ:
				aluOp = ALU_NEQ;
			default:
				aluOp = ALU_ADD; // also address and pass-through ops
		endcase
	end

endmodule

`default_nettype wire

// ==== src/flowDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module flowDecoder (
	input logic [cpuCtrlPkg::OPCODE_W-1:0] opcode,
	output logic pcSrc,
	output logic jump,
	output logic jumpReg,
	output logic jumpAndLink
);
	import cpuCtrlPkg::*;

	// program counter steering
	always_comb
	begin
		pcSrc = 1'b0;
		jump = 1'b0;
		jumpReg = 1'b0;
		jumpAndLink = 1'b0;
		case (opcode)
			OP_BEQ, OP_BNEQ, OP_BEQZ, OP_BNEQZ, OP_BGT, OP_BLT, OP_BGTZ, OP_BLTZ:
				pcSrc = 1'b1; // taken only if the ALU compare holds
			OP_JUMP:
				jump = 1'b1;
			OP_JR:
				jumpReg = 1'b1;
			OP_JAL:
				jumpAndLink = 1'b1; // link register written by datapath
			default:
				pcSrc = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/ioDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module ioDecoder (
	input logic [cpuCtrlPkg::OPCODE_W-1:0] opcode,
	input logic ioFlag,
	input logic uartFlag,
	output logic portOut,
	output logic uartWrite,
	output logic halt,
	output logic [cpuCtrlPkg::MEMOUT_W-1:0] memOut
);
	import cpuCtrlPkg::*;

	logic isIn;
	logic isOut;
	logic isRecv;

	assign isIn = (opcode == OP_IN);
	assign isOut = (opcode == OP_OUT);
	assign isRecv = (opcode == OP_RECV);

	// stall while the port or the serial receiver is not ready
	assign halt = (opcode == OP_HALT)
		| ((isIn | isOut) & ioFlag)
		| (isRecv & uartFlag);

	assign portOut = isOut;
	assign uartWrite = (opcode == OP_SEND);

	// writeback source for external input
	always_comb
	begin
		if (isIn)
			memOut = MO_PORT;
		else if (isRecv)
			memOut = MO_UART;
		else
			memOut = MO_NONE;
	end

endmodule

`default_nettype wire

// ==== src/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input logic [cpuCtrlPkg::OPCODE_W-1:0] opcode,
	input logic ioFlag,
	input logic uartFlag,
	output logic regWrite,
	output logic regDst,
	output logic [cpuCtrlPkg::ALUSRC_W-1:0] aluSrc,
	output logic [cpuCtrlPkg::MEMTOREG_W-1:0] memToReg,
	output logic memWrite,
	output logic [cpuCtrlPkg::ALUOP_W-1:0] aluOp,
	output logic pcSrc,
	output logic jump,
	output logic jumpReg,
	output logic jumpAndLink,
	output logic portOut,
	output logic [cpuCtrlPkg::MEMOUT_W-1:0] memOut,
	output logic uartWrite,
	output logic halt
);

	datapathDecoder datapathDecoder_inst (
		.opcode(opcode),
		.regWrite(regWrite),
		.regDst(regDst),
		.aluSrc(aluSrc),
		.memToReg(memToReg),
		.memWrite(memWrite),
		.aluOp(aluOp)
	);

	// branch and jump selects
	flowDecoder flowDecoder_inst (
		.opcode(opcode),
		.pcSrc(pcSrc),
		.jump(jump),
		.jumpReg(jumpReg),
		.jumpAndLink(jumpAndLink)
	);

	// port, serial and halt handling
	ioDecoder ioDecoder_inst (
		.opcode(opcode),
		.ioFlag(ioFlag),
		.uartFlag(uartFlag),
		.portOut(portOut),
		.uartWrite(uartWrite),
		.halt(halt),
		.memOut(memOut)
	);

endmodule

`default_nettype wire

// ==== tests/controlUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;
	import cpuCtrlPkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam int MAX_STIM = 64;
	localparam int NUM_RAND = 16;
	localparam int MAX_DRAWS = 1000;
	localparam int WORD_W = 21;

	logic clk;
	logic arstN;
	logic [OPCODE_W-1:0] opcode;
	logic ioFlag;
	logic uartFlag;
	logic regWrite;
	logic regDst;
	logic [ALUSRC_W-1:0] aluSrc;
	logic [MEMTOREG_W-1:0] memToReg;
	logic memWrite;
	logic [ALUOP_W-1:0] aluOp;
	logic pcSrc;
	logic jump;
	logic jumpReg;
	logic jumpAndLink;
	logic portOut;
	logic [MEMOUT_W-1:0] memOut;
	logic uartWrite;
	logic halt;
	logic [WORD_W-1:0] ctrlWord;

	logic [31:0] stimMem [MAX_STIM];
	logic [31:0] lcgState;
	int numStim;
	int numTests;
	int passCount;
	int failCount;

	controlUnit controlUnit_inst (
		.opcode(opcode),
		.ioFlag(ioFlag),
		.uartFlag(uartFlag),
		.regWrite(regWrite),
		.regDst(regDst),
		.aluSrc(aluSrc),
		.memToReg(memToReg),
		.memWrite(memWrite),
		.aluOp(aluOp),
		.pcSrc(pcSrc),
		.jump(jump),
		.jumpReg(jumpReg),
		.jumpAndLink(jumpAndLink),
		.portOut(portOut),
		.memOut(memOut),
		.uartWrite(uartWrite),
		.halt(halt)
	);

	// outputs packed in port order like the stimulus file
	assign ctrlWord = {regWrite, regDst, aluSrc, memToReg, memWrite, aluOp,
		pcSrc, jump, jumpReg, jumpAndLink, portOut, memOut, uartWrite, halt};

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		arstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		arstN <= 1'b1;
	end

	function automatic logic [31:0] nextRand(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// send and recv sit past the gap above jal
	function automatic bit isKeptOp(input logic [OPCODE_W-1:0] op);
		return (op <= OP_JAL) || (op == OP_SEND) || (op == OP_RECV);
	endfunction

	task automatic compareWord(input string testName, input logic [WORD_W-1:0] expected,
		input logic [WORD_W-1:0] actual);
		if (actual !== expected)
		begin
			$display("** Error: %s expected %h actual %h", testName, expected, actual);
			failCount++;
		end
		else
		begin
			$display("%s passed", testName);
			passCount++;
		end
	endtask

	task automatic applyTest(input string testName, input logic [OPCODE_W-1:0] op,
		input logic io, input logic uart, input logic [WORD_W-1:0] expected);
		@(posedge clk);
		opcode <= op;
		ioFlag <= io;
		uartFlag <= uart;
		@(negedge clk); // settled half a cycle later
		compareWord(testName, expected, ctrlWord);
	endtask

	initial
	begin
		string name;
		logic [31:0] entry;
		logic [OPCODE_W-1:0] randOp;
		int drawn;

		opcode = '0;
		ioFlag = 1'b0;
		uartFlag = 1'b0;
		passCount = 0;
		failCount = 0;
		numStim = 0;
		drawn = 0;
		lcgState = 32'h70d5_cb81;

		for (int i = 0; i < MAX_STIM; i++)
			stimMem[i] = '1; // marks the end of the loaded lines
		$readmemh("tests/controlUnitStim.txt", stimMem);
		while (numStim < MAX_STIM && stimMem[numStim] != '1)
			numStim++;
		numTests = numStim + NUM_RAND;
		if (numStim == 0)
		begin
			$display("the stimulus file held no tests");
			failCount++;
		end

		wait (arstN === 1'b1);

		for (int i = 0; i < numStim; i++)
		begin
			entry = stimMem[i];
			name = $sformatf("stim%0d op%02h io%0b uart%0b", i, entry[28:23],
				entry[22], entry[21]);
			applyTest(name, entry[28:23], entry[22], entry[21], entry[20:0]);
		end

		// unused opcodes must decode like nop whatever the flags
		for (int tries = 0; tries < MAX_DRAWS && drawn < NUM_RAND; tries++)
		begin
			lcgState = nextRand(lcgState);
			randOp = lcgState[29:24];
			if (!isKeptOp(randOp))
			begin
				name = $sformatf("rand%0d op%02h", drawn, randOp);
				applyTest(name, randOp, lcgState[17], lcgState[19], '0);
				drawn++;
			end
		end
		if (drawn < NUM_RAND)
		begin
			$display("the random generator gave only %0d unused opcodes", drawn);
			failCount++;
		end

		$display("tests run %0d, passed %0d, failed %0d", passCount + failCount,
			passCount, failCount);
		if (failCount == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial
	begin
		wait (numTests > 0);
		#((2 * numTests + RESET_CYCLES) * CLK_PERIOD);
		$display("timeout, the tests did not finish in time");
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/controlUnitStim.txt ====
// opcode[28:23] ioFlag[22] uartFlag[21] expected[20:0]
// expected: regWrite regDst aluSrc[2] memToReg[2] memWrite aluOp[5] pcSrc jump jumpReg jal portOut memOut[2] uartWrite halt
00000000 // nop
00600000 // nop, both flags
00800001 // halt
00E00001 // halt, both flags
01180000 // add
01920000 // addi
02180200 // sub
02920200 // subi
03180400 // mult
03980600 // div
04181400 // slt
04901200 // shr
05101000 // shl
05928000 // lw
06120000 // li
06824000 // sw
07020080 // jump
07800040 // jr
08180E00 // xor
08980A00 // and
09180C00 // or
09900800 // not
0A120E00 // xori
0A920A00 // andi
0B120C00 // ori
0B801900 // beq
0C001F00 // bneq
0C801900 // beqz
0D001F00 // bneqz
0D801700 // bgt
0E001500 // blt
0E801700 // bgtz
0F001500 // bltz
0F920004 // in
0FD20005 // in, port busy
0FB20004 // in, uart flag ignored
10028010 // out
10428011 // out, port busy
10228010 // out, uart flag ignored
10900020 // jal
19828002 // send
1A120008 // recv
1A320009 // recv, receiver empty
1A520008 // recv, io flag ignored
11000000 // dropped 0x22
15400000 // dropped 0x2a, io flag
19000000 // dropped 0x32
1FE00000 // unused 0x3f, both flags

// ==== build.f ====
src/cpuCtrlPkg.sv
src/datapathDecoder.sv
src/flowDecoder.sv
src/ioDecoder.sv
src/controlUnit.sv
tests/controlUnitTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= controlUnitTb
FILELIST ?= build.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
PASS_MSG ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
